// ==== src/ac_board_pkg.sv ====
package ac_board_pkg;

   ////////////////////////////////////////////////////////////
   // Word format
   ////////////////////////////////////////////////////////////

   // Index of the sign bit, which is also the negative flag
   localparam int word_msb = 15;

   // One machine word, as held by the accumulator and moved on the bus
   typedef logic [word_msb:0] word_t;

   ////////////////////////////////////////////////////////////
   // Command channel
   ////////////////////////////////////////////////////////////

   // Opcodes accepted by the command controller
   typedef enum logic [2:0] {
      OP_LOAD = 3'd0,   // Write command data into the accumulator
      OP_READ = 3'd1,   // Return the accumulator on the response channel
      OP_INC  = 3'd2,   // Count up by one
      OP_DEC  = 3'd3,   // Count down by one
      OP_CLL  = 3'd4,   // Clear the link
      OP_CML  = 3'd5    // Complement the link
   } ac_op_t;

   // Controller sequencing, one micro-step per command
   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,   // Waiting for a command
      ST_EXEC = 2'd1,   // Strobes active for one cycle
      ST_RESP = 2'd2    // Read word waiting on the response channel
   } ctrl_state_t;

endpackage

// ==== src/ibus_if.sv ====
`timescale 1ns/1ns

// Internal bus of the accumulator section
// Write and read data run on separate paths in place of the shared bus
interface ibus_if;

   // Strobes from the controller, each valid for one cycle
   logic wac;     // Load accumulator from wdata
   logic rac;     // Accumulator drives rdata
   logic stp;     // Step accumulator by one
   logic dn;      // Step direction, high counts down
   logic cll;     // Clear link
   logic cml;     // Complement link

   // Data paths
   ac_board_pkg::word_t wdata;
   ac_board_pkg::word_t rdata;

   // Carry or borrow out of the accumulator into the link
   logic accpl;

   modport ctrl (output wac, rac, stp, dn, cll, cml, wdata, input rdata);

   modport acc (input wac, rac, stp, dn, wdata, output rdata, accpl);

   modport link (input cll, cml, accpl);

endinterface

// ==== src/ac_ctrl.sv ====
`timescale 1ns/1ns

// Command controller
// Turns one accepted command into one cycle of bus strobes
module ac_ctrl (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 cmd_valid,
   output logic                 cmd_ready,
   input  ac_board_pkg::ac_op_t cmd_op,
   input  ac_board_pkg::word_t  cmd_data,
   output logic                 rsp_valid,
   input  logic                 rsp_ready,
   output ac_board_pkg::word_t  rsp_data,
   ibus_if.ctrl                 bus
);

   ac_board_pkg::ctrl_state_t state;
   ac_board_pkg::ac_op_t      op_q;
   ac_board_pkg::word_t       data_q;
   logic                      cmd_fire;

   // Handshake status follows the state directly
   assign cmd_ready = (state == ac_board_pkg::ST_IDLE);
   assign rsp_valid = (state == ac_board_pkg::ST_RESP);
   assign cmd_fire  = cmd_valid & cmd_ready;

   ////////////////////////////////////////////////////////////
   // Sequencer
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ac_board_pkg::ST_IDLE;
         op_q  <= ac_board_pkg::OP_LOAD;
      end else begin
         case (state)
            ac_board_pkg::ST_IDLE: begin
               if (cmd_fire) begin
                  state <= ac_board_pkg::ST_EXEC;
                  op_q  <= cmd_op;
               end
            end
            // Only a read waits for the response channel
            ac_board_pkg::ST_EXEC: begin
               if (op_q == ac_board_pkg::OP_READ) begin
                  state <= ac_board_pkg::ST_RESP;
               end else begin
                  state <= ac_board_pkg::ST_IDLE;
               end
            end
            ac_board_pkg::ST_RESP: begin
               if (rsp_ready) begin
                  state <= ac_board_pkg::ST_IDLE;
               end
            end
            default: state <= ac_board_pkg::ST_IDLE;
         endcase
      end
   end

   // Command word and read response
   always_ff @(posedge clk) begin
      if (cmd_fire) begin
         data_q <= cmd_data;
      end
      // Sampled once and held under back-pressure
      if (state == ac_board_pkg::ST_EXEC && op_q == ac_board_pkg::OP_READ) begin
         rsp_data <= bus.rdata;
      end
   end

   ////////////////////////////////////////////////////////////
   // Strobe decode
   ////////////////////////////////////////////////////////////

   // Step and direction split the same way as the up and down count lines
   always_comb begin
      bus.wac   = 1'b0;
      bus.rac   = 1'b0;
      bus.stp   = 1'b0;
      bus.dn    = 1'b0;
      bus.cll   = 1'b0;
      bus.cml   = 1'b0;
      bus.wdata = data_q;
      if (state == ac_board_pkg::ST_EXEC) begin
         case (op_q)
            ac_board_pkg::OP_LOAD: bus.wac = 1'b1;
            ac_board_pkg::OP_READ: bus.rac = 1'b1;
            ac_board_pkg::OP_INC:  bus.stp = 1'b1;
            ac_board_pkg::OP_DEC: begin
               bus.stp = 1'b1;
               bus.dn  = 1'b1;
            end
            ac_board_pkg::OP_CLL:  bus.cll = 1'b1;
            ac_board_pkg::OP_CML:  bus.cml = 1'b1;
            default: ;
         endcase
      end
   end

   // Response held until taken
   a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data));

   // No strobe outside the execute step
   a_strobe_exec: assert property (@(posedge clk) disable iff (!rst_n)
      (bus.wac | bus.rac | bus.stp | bus.cll | bus.cml)
         |-> state == ac_board_pkg::ST_EXEC);

endmodule

// ==== src/accumulator.sv ====
`timescale 1ns/1ns

// Accumulator register
// Parallel load, up/down count by one, bus read and flags
module accumulator (
   input  logic                clk,
   input  logic                rst_n,
   ibus_if.acc                 bus,
   output ac_board_pkg::word_t ac,
   output logic                fn,
   output logic                fz
);

   ac_board_pkg::word_t ac_step;
   logic                at_top;
   logic                at_bottom;

   ////////////////////////////////////////////////////////////
   // Counter
   ////////////////////////////////////////////////////////////

   // Next count, wraps modulo 2^16 in both directions
   assign ac_step = bus.dn ? ac - ac_board_pkg::word_t'(1) : ac + ac_board_pkg::word_t'(1);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ac <= '0;
      end else if (bus.wac) begin
         ac <= bus.wdata;
      end else if (bus.stp) begin
         ac <= ac_step;
      end
   end

   // Terminal counts for carry and borrow
   assign at_top    = (ac == '1);
   assign at_bottom = (ac == '0);

   // Carry on up from all ones, borrow on down from zero
   assign bus.accpl = bus.stp & (bus.dn ? at_bottom : at_top);

   // Read path, idle at zero when not selected
   assign bus.rdata = bus.rac ? ac : '0;

   ////////////////////////////////////////////////////////////
   // Flags
   ////////////////////////////////////////////////////////////

   // Sign bit doubles as negative flag
   assign fn = ac[ac_board_pkg::word_msb];

   // Zero flag is a full-word compare
   assign fz = at_bottom;

   // Load and step come from exclusive opcodes
   a_no_load_step: assert property (@(posedge clk) disable iff (!rst_n)
      !(bus.wac && bus.stp));

endmodule

// ==== src/link_reg.sv ====
`timescale 1ns/1ns

// Link register
// One bit, toggled by accumulator carry/borrow or by command
module link_reg (
   input  logic clk,
   input  logic rst_n,
   ibus_if.link bus,
   output logic link
);

   logic toggle;

   // Carry/borrow and complement share the toggle path
   assign toggle = bus.cml | bus.accpl;

   ////////////////////////////////////////////////////////////
   // Register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         link <= 1'b0;
      end else if (bus.cll) begin
         // Clear wins over any toggle
         link <= 1'b0;
      end else if (toggle) begin
         link <= ~link;
      end
   end

   // Link commands are exclusive
   a_cll_cml: assert property (@(posedge clk) disable iff (!rst_n)
      !(bus.cll && bus.cml));

   // A carry or borrow is never paired with a link command
   a_accpl_alone: assert property (@(posedge clk) disable iff (!rst_n)
      bus.accpl |-> !(bus.cll || bus.cml));

endmodule

// ==== src/ac_board.sv ====
`timescale 1ns/1ns

// Accumulator section top level
// Controller, accumulator and link share one internal bus
module ac_board (
   input  logic                 clk,
   input  logic                 rst_n,

   // Command channel
   input  logic                 cmd_valid,
   output logic                 cmd_ready,
   input  ac_board_pkg::ac_op_t cmd_op,
   input  ac_board_pkg::word_t  cmd_data,

   // Response channel
   output logic                 rsp_valid,
   input  logic                 rsp_ready,
   output ac_board_pkg::word_t  rsp_data,

   // Register and flag view
   output ac_board_pkg::word_t  ac,
   output logic                 link,
   output logic                 fn,
   output logic                 fz
);

   ibus_if u_bus ();

   ac_ctrl u_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .cmd_op    (cmd_op),
      .cmd_data  (cmd_data),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_data  (rsp_data),
      .bus       (u_bus.ctrl)
   );

   accumulator u_acc (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (u_bus.acc),
      .ac    (ac),
      .fn    (fn),
      .fz    (fz)
   );

   link_reg u_link (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (u_bus.link),
      .link  (link)
   );

endmodule

// ==== tb/tb_ac_board.sv ====
`timescale 1ns/1ns

module tb_ac_board;

   localparam int n_directed  = 7;
   localparam int n_random    = 400;
   // About 12 cycles per command at worst, plus reset and drain margin
   localparam int cycle_limit = (n_directed + n_random) * 12 + 1000;

   logic                 clk;
   logic                 rst_n;
   logic                 cmd_valid;
   logic                 cmd_ready;
   ac_board_pkg::ac_op_t cmd_op;
   ac_board_pkg::word_t  cmd_data;
   logic                 rsp_valid;
   logic                 rsp_ready;
   ac_board_pkg::word_t  rsp_data;
   ac_board_pkg::word_t  ac;
   logic                 link;
   logic                 fn;
   logic                 fz;

   // Scoreboard
   int                   errors = 0;
   int                   n_reads = 0;
   int                   n_rsp = 0;
   int                   cycles = 0;
   int                   due = 0;      // Negedges until the accepted command is checked
   logic                 rsp_pending = 1'b0;
   ac_board_pkg::word_t  rsp_exp = '0;

   ac_board u_dut (.*);

   ////////////////////////////////////////////////////////////
   // Reference model and compare tasks
   ////////////////////////////////////////////////////////////

   // Next {link, ac} after one command
   function automatic logic [16:0] next_regs(input ac_board_pkg::word_t cur_ac,
         input logic cur_link, input ac_board_pkg::ac_op_t op, input ac_board_pkg::word_t data);
      ac_board_pkg::word_t nac;
      logic                nlink;
      nac   = cur_ac;
      nlink = cur_link;
      case (op)
         ac_board_pkg::OP_LOAD: nac = data;
         ac_board_pkg::OP_INC: begin
            // Carry out of all ones
            if (cur_ac == 16'hffff) nlink = ~cur_link;
            nac = cur_ac + 16'd1;
         end
         ac_board_pkg::OP_DEC: begin
            // Borrow out of zero
            if (cur_ac == 16'h0000) nlink = ~cur_link;
            nac = cur_ac - 16'd1;
         end
         ac_board_pkg::OP_CLL: nlink = 1'b0;
         ac_board_pkg::OP_CML: nlink = ~cur_link;
         default: ;
      endcase
      return {nlink, nac};
   endfunction

   task automatic check_word(input string name, input ac_board_pkg::word_t exp,
         input ac_board_pkg::word_t act);
      if (act !== exp) begin
         errors++;
         $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         errors++;
         $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
      end
   endtask

   // Hold the command until the controller takes it
   task automatic send_cmd(input ac_board_pkg::ac_op_t op, input ac_board_pkg::word_t data);
      cmd_valid = 1'b1;
      cmd_op    = op;
      cmd_data  = data;
      @(negedge clk);
      while (!cmd_ready) @(negedge clk);
      @(posedge clk);
      #1;
      cmd_valid = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // Clock, watchdog, response ready
   ////////////////////////////////////////////////////////////

   initial begin : clock_gen
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin : watchdog
      while (cycles < cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout after %0d cycles, controller stuck in state %s", cycles,
         u_dut.u_ctrl.state.name());
      $display("TESTS FAILED");
      $finish;
   end

   // Random back-pressure, drawn mid-cycle once per response
   initial begin : rsp_drive
      int unsigned hold;
      rsp_ready = 1'b0;
      forever begin
         @(negedge clk);
         if (rsp_valid) begin
            hold = $urandom_range(8, 0);
            @(posedge clk);
            #1;
            repeat (hold) begin
               @(posedge clk);
               #1;
            end
            rsp_ready = 1'b1;
            @(posedge clk);
            #1;
            rsp_ready = 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Compare process, samples at the falling edge
   ////////////////////////////////////////////////////////////

   initial begin : compare
      ac_board_pkg::word_t  model_ac;
      logic                 model_link;
      ac_board_pkg::ac_op_t op_q;
      ac_board_pkg::word_t  data_q;
      logic [16:0]          nxt;
      model_ac   = '0;
      model_link = 1'b0;
      op_q       = ac_board_pkg::OP_LOAD;
      data_q     = '0;
      @(posedge rst_n);
      @(negedge clk);
      check_bit("cmd_ready", 1'b1, cmd_ready);
      check_bit("rsp_valid", 1'b0, rsp_valid);
      forever begin
         // Registers settle two rising edges after acceptance
         if (due > 0) begin
            due--;
            if (due == 0) begin
               nxt        = next_regs(model_ac, model_link, op_q, data_q);
               model_link = nxt[16];
               model_ac   = nxt[15:0];
               if (op_q == ac_board_pkg::OP_READ) begin
                  rsp_pending = 1'b1;
                  rsp_exp     = model_ac;
               end
            end
         end
         // Flags and registers at every check point
         check_word("ac", model_ac, ac);
         check_bit("link", model_link, link);
         check_bit("fn", model_ac[ac_board_pkg::word_msb], fn);
         check_bit("fz", model_ac == '0, fz);
         if (rsp_valid) begin
            if (!rsp_pending) begin
               errors++;
               $display("Response at %0t with no read outstanding", $time);
            end
            check_word("rsp_data", rsp_exp, rsp_data);
            check_bit("cmd_ready", 1'b0, cmd_ready);
            if (rsp_ready) begin
               rsp_pending = 1'b0;
               n_rsp++;
            end
         end else if (rsp_pending) begin
            errors++;
            rsp_pending = 1'b0;
            $display("rsp_valid dropped at %0t before the response was taken", $time);
         end
         // Accepted on the coming rising edge
         if (cmd_valid && cmd_ready) begin
            op_q   = cmd_op;
            data_q = cmd_data;
            due    = 2;
            if (cmd_op == ac_board_pkg::OP_READ) n_reads++;
         end
         @(negedge clk);
      end
   end

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   initial begin : drive
      int unsigned          gap;
      int unsigned          pick;
      ac_board_pkg::ac_op_t op;
      ac_board_pkg::word_t  data;
      void'($urandom(32'h5feb_d9f8));
      rst_n     = 1'b0;
      cmd_valid = 1'b0;
      cmd_op    = ac_board_pkg::OP_LOAD;
      cmd_data  = '0;
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(posedge clk);
      #1;
      // Directed run through both wrap points
      send_cmd(ac_board_pkg::OP_LOAD, 16'hffff);
      send_cmd(ac_board_pkg::OP_READ, '0);
      send_cmd(ac_board_pkg::OP_INC, '0);
      send_cmd(ac_board_pkg::OP_DEC, '0);
      send_cmd(ac_board_pkg::OP_DEC, '0);
      send_cmd(ac_board_pkg::OP_CLL, '0);
      send_cmd(ac_board_pkg::OP_CML, '0);
      repeat (n_random) begin
         gap = $urandom_range(2, 0);
         repeat (gap) begin
            @(posedge clk);
            #1;
         end
         // Load data leans toward the terminal counts
         pick = $urandom_range(3, 0);
         case (pick)
            0: data = 16'h0000;
            1: data = 16'hffff;
            2: data = 16'h7fff;
            default: data = ac_board_pkg::word_t'($urandom());
         endcase
         op = ac_board_pkg::ac_op_t'(3'($urandom_range(5, 0)));
         send_cmd(op, data);
      end
      while (due != 0 || rsp_pending) @(posedge clk);
      repeat (2) @(posedge clk);
      if (n_reads != n_rsp) $display("%0d reads issued but %0d responses taken", n_reads, n_rsp);
      $display("Errors: %0d, reads: %0d, responses: %0d", errors, n_reads, n_rsp);
      if (errors == 0 && n_reads == n_rsp) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
src/ac_board_pkg.sv
src/ibus_if.sv
src/ac_ctrl.sv
src/accumulator.sv
src/link_reg.sv
src/ac_board.sv
tb/tb_ac_board.sv

// ==== Makefile ====
TOP = tb_ac_board

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
